// ==== cpu.f ====
common/cpu_isa_pkg.sv
common/cpu_pipe_pkg.sv
hdl/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu.sv
bench/clock_gen.sv
bench/cpu_assertions.sv
bench/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cpu testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpu.f --top-module cpu_tb -o cpu_sim \
    && ./obj_dir/cpu_sim 2>&1 | tee sim.log \
    || { echo "Build or simulation ended with an error"; exit 1; }

grep -q "Test failures found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0

// ==== bench/cpu_tb.sv ====
`timescale 1ns/100ps

module cpu_tb;

    localparam int PROG_DEPTH   = 32;
    localparam int CHAIN_START  = 20;
    localparam int CHAIN_LEN    = 8;
    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 20;
    localparam int HOLD_TIMEOUT = 200;
    localparam int DONE_TIMEOUT = 300;
    // Middle of the ADDIU chain, and well past the last instruction
    localparam logic [31:0] HOLD_PC = 32'd92;
    localparam logic [31:0] DONE_PC = 32'd160;

    localparam logic [31:0] LFSR_SEED = 32'hd85b_dfcb;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // MIPS encodings
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] FN_ADDU   = 6'h21;
    localparam logic [5:0] FN_SUBU   = 6'h23;
    localparam logic [5:0] FN_AND    = 6'h24;
    localparam logic [5:0] FN_OR     = 6'h25;
    localparam logic [5:0] FN_SLT    = 6'h2a;

    logic        clk;
    logic        rst;
    logic        ena;
    logic [31:0] instr;
    logic [4:0]  dbg_addr;
    logic [31:0] pc;
    logic [31:0] dbg_data;

    logic [31:0] prog [PROG_DEPTH];
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    bit          timed_out;

    // Result table
    string       exp_name [$];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_val [$];

    clock_gen clock_gen_inst (
        .clk(clk)
    );

    cpu dut (
        .clk(clk),
        .rst(rst),
        .ena(ena),
        .instr(instr),
        .dbg_addr(dbg_addr),
        .pc(pc),
        .dbg_data(dbg_data)
    );

    bind cpu cpu_assertions cpu_assertions_inst (
        .clk(clk),
        .rst(rst),
        .ena(ena),
        .stall(stall),
        .pc(pc)
    );

    // Words past the table fetch as 0, which is a no-op
    assign instr = (pc[31:7] == '0) ? prog[pc[6:2]] : 32'h0;

    function automatic logic [31:0] encode_rtype(input logic [5:0] funct, input logic [4:0] rd,
                                                 input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit
    task automatic draw_imm16(output logic [15:0] imm);
        for (int b = 0; b < 16; b++) begin
            imm = {imm[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic add_expect(input string name, input logic [4:0] addr,
                              input logic [31:0] value);
        exp_name.push_back(name);
        exp_reg.push_back(addr);
        exp_val.push_back(value);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic build_program();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] v6;
        logic [31:0] sum;
        logic [15:0] imm;
        logic [4:0]  src;
        prog = '{default: 32'h0};
        v1 = 32'd7;
        v2 = 32'hffff_fffd;
        v3 = v1 + v2;
        v4 = v2 - v1;
        v6 = v4 | v1;
        prog[0]  = encode_itype(OPC_ADDIU, 5'd0, 5'd1, v1[15:0]);
        prog[1]  = encode_itype(OPC_ADDIU, 5'd0, 5'd2, v2[15:0]);
        prog[2]  = encode_rtype(FN_ADDU, 5'd3, 5'd1, 5'd2);
        prog[3]  = encode_rtype(FN_SUBU, 5'd4, 5'd2, 5'd1);
        prog[4]  = encode_rtype(FN_AND, 5'd5, 5'd4, 5'd3);
        prog[5]  = encode_rtype(FN_OR, 5'd6, 5'd4, 5'd1);
        prog[6]  = encode_rtype(FN_SLT, 5'd7, 5'd4, 5'd2);
        prog[7]  = encode_rtype(FN_SLT, 5'd8, 5'd2, 5'd4);
        prog[8]  = encode_itype(OPC_ADDIU, 5'd0, 5'd9, 16'h0040);
        prog[9]  = encode_itype(OPC_SW, 5'd9, 5'd6, 16'h0000);
        prog[10] = encode_itype(OPC_SW, 5'd9, 5'd3, 16'h0004);
        prog[11] = encode_itype(OPC_LW, 5'd9, 5'd10, 16'h0000);
        prog[12] = encode_rtype(FN_ADDU, 5'd11, 5'd10, 5'd1);
        prog[13] = encode_itype(OPC_LW, 5'd9, 5'd12, 16'h0004);
        prog[14] = encode_rtype(FN_SUBU, 5'd13, 5'd12, 5'd10);
        // Taken branch over the next word
        prog[15] = encode_itype(OPC_BEQ, 5'd3, 5'd12, 16'h0001);
        prog[16] = encode_itype(OPC_ADDIU, 5'd0, 5'd14, 16'h0055);
        prog[17] = encode_itype(OPC_ADDIU, 5'd0, 5'd15, 16'h0066);
        prog[18] = encode_itype(OPC_BNE, 5'd3, 5'd12, 16'h0001);
        prog[19] = encode_itype(OPC_ADDIU, 5'd0, 5'd16, 16'h0077);
        sum = 32'h0;
        for (int i = 0; i < CHAIN_LEN; i++) begin
            draw_imm16(imm);
            src = (i == 0) ? 5'd0 : 5'd17;
            prog[5'(CHAIN_START + i)] = encode_itype(OPC_ADDIU, src, 5'd17, imm);
            sum = sum + {{16{imm[15]}}, imm};
        end
        // Write to r0 must be dropped
        prog[28] = encode_itype(OPC_ADDIU, 5'd0, 5'd0, 16'h1234);
        add_expect("reg0_zero", 5'd0, 32'h0);
        add_expect("addiu_pos", 5'd1, v1);
        add_expect("addiu_neg", 5'd2, v2);
        add_expect("addu_fwd", 5'd3, v3);
        add_expect("subu_fwd", 5'd4, v4);
        add_expect("and_neg", 5'd5, v4 & v3);
        add_expect("or_neg", 5'd6, v6);
        add_expect("slt_true", 5'd7, 32'd1);
        add_expect("slt_false", 5'd8, 32'd0);
        add_expect("base_addr", 5'd9, 32'h40);
        add_expect("lw_after_sw", 5'd10, v6);
        add_expect("load_use_add", 5'd11, v6 + v1);
        add_expect("lw_second", 5'd12, v3);
        add_expect("load_use_sub", 5'd13, v3 - v6);
        add_expect("beq_shadow", 5'd14, 32'h0);
        add_expect("beq_target", 5'd15, 32'h66);
        add_expect("bne_fallthrough", 5'd16, 32'h77);
        add_expect("addiu_chain", 5'd17, sum);
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        dbg_addr = addr;
        @(negedge clk);
        data = dbg_data;
    endtask

    task automatic wait_for_pc(input logic [31:0] target, input int max_cycles,
                               input string what);
        int cycles;
        cycles = 0;
        while (pc < target && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (pc < target) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: pc never reached %0d while waiting for %s", target, what);
        end
    endtask

    task automatic hold_enable_low();
        logic [31:0] held_pc;
        @(posedge clk);
        #1;
        ena = 1'b0;
        held_pc = pc;
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            @(negedge clk);
            check_value("ena_hold_pc", held_pc, pc);
            @(posedge clk);
        end
        #1;
        ena = 1'b1;
    endtask

    task automatic check_registers();
        logic [31:0] value;
        for (int i = 0; i < exp_name.size(); i++) begin
            read_reg(exp_reg[i], value);
            check_value(exp_name[i], exp_val[i], value);
        end
    endtask

    initial begin
        logic [31:0] value;
        rst = 1'b1;
        ena = 1'b0;
        dbg_addr = '0;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        lfsr_state = LFSR_SEED;
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        // ena stays low so the reset state can be read out
        @(negedge clk);
        check_value("reset_pc", 32'h0, pc);
        for (int r = 0; r < 32; r++) begin
            read_reg(5'(r), value);
            check_value($sformatf("reset_r%0d", r), 32'h0, value);
        end
        @(posedge clk);
        #1;
        ena = 1'b1;
        wait_for_pc(HOLD_PC, HOLD_TIMEOUT, "the ena hold point");
        if (!timed_out) begin
            hold_enable_low();
        end
        if (!timed_out) begin
            wait_for_pc(DONE_PC, DONE_TIMEOUT, "the end of the program");
        end
        if (!timed_out) begin
            check_registers();
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== bench/cpu_assertions.sv ====
`timescale 1ns/100ps

module cpu_assertions (
    input logic        clk,
    input logic        rst,
    input logic        ena,
    input logic        stall,
    input logic [31:0] pc
);

    // pc clears on reset and stays at 0 as long as reset is held
    pc_reset_a: assert property (@(posedge clk) rst |=> pc == 32'h0)
        else $error("pc is not zero while reset is active");

    // Frozen pipeline
    ena_hold_a: assert property (@(posedge clk) (!rst && !ena) |=> $stable(pc))
        else $error("pc changed while ena was low");

    stall_hold_a: assert property (@(posedge clk) (!rst && stall) |=> $stable(pc))
        else $error("pc changed during a load-use stall");

    pc_align_a: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen (
    output logic clk
);

    // 8 ns period
    localparam int HALF_PERIOD_NS = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

// ==== hdl/cpu.sv ====
`timescale 1ns/100ps

module cpu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ena,
    input  cpu_pipe_pkg::word_t     instr,
    input  cpu_pipe_pkg::reg_addr_t dbg_addr,
    output cpu_pipe_pkg::word_t     pc,
    output cpu_pipe_pkg::word_t     dbg_data
);

    // Fetch to decode
    cpu_pipe_pkg::word_t     if_pc4;
    cpu_pipe_pkg::word_t     if_instr;

    // Decode back to fetch
    logic                    stall;
    logic                    branch_taken;
    cpu_pipe_pkg::word_t     branch_target;

    // ID/EX
    cpu_pipe_pkg::alu_op_e   ex_op;
    cpu_pipe_pkg::word_t     ex_a;
    cpu_pipe_pkg::word_t     ex_b;
    cpu_pipe_pkg::word_t     ex_store_data;
    cpu_pipe_pkg::reg_addr_t ex_dst;
    logic                    ex_wena;
    logic                    ex_load;
    logic                    ex_store;
    cpu_pipe_pkg::word_t     ex_result;

    // EX/MEM
    cpu_pipe_pkg::word_t     mem_result;
    cpu_pipe_pkg::word_t     mem_store_data;
    cpu_pipe_pkg::reg_addr_t mem_dst;
    logic                    mem_wena;
    logic                    mem_load;
    logic                    mem_store;
    cpu_pipe_pkg::word_t     mem_fwd_data;

    // Write-back
    cpu_pipe_pkg::word_t     wb_data;
    cpu_pipe_pkg::reg_addr_t wb_dst;
    logic                    wb_wena;

    fetch_stage fetch_stage_inst (
        .clk(clk),
        .rst(rst),
        .ena(ena),
        .stall(stall),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .instr(instr),
        .pc(pc),
        .if_pc4(if_pc4),
        .if_instr(if_instr)
    );

    decode_stage decode_stage_inst (
        .clk(clk),
        .rst(rst),
        .ena(ena),
        .if_pc4(if_pc4),
        .if_instr(if_instr),
        .ex_result(ex_result),
        .mem_fwd_data(mem_fwd_data),
        .mem_dst(mem_dst),
        .mem_wena(mem_wena),
        .wb_data(wb_data),
        .wb_dst(wb_dst),
        .wb_wena(wb_wena),
        .dbg_addr(dbg_addr),
        .stall(stall),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .ex_op(ex_op),
        .ex_a(ex_a),
        .ex_b(ex_b),
        .ex_store_data(ex_store_data),
        .ex_dst(ex_dst),
        .ex_wena(ex_wena),
        .ex_load(ex_load),
        .ex_store(ex_store),
        .dbg_data(dbg_data)
    );

    execute_stage execute_stage_inst (
        .clk(clk),
        .rst(rst),
        .ena(ena),
        .ex_op(ex_op),
        .ex_a(ex_a),
        .ex_b(ex_b),
        .ex_store_data(ex_store_data),
        .ex_dst(ex_dst),
        .ex_wena(ex_wena),
        .ex_load(ex_load),
        .ex_store(ex_store),
        .ex_result(ex_result),
        .mem_result(mem_result),
        .mem_store_data(mem_store_data),
        .mem_dst(mem_dst),
        .mem_wena(mem_wena),
        .mem_load(mem_load),
        .mem_store(mem_store)
    );

    memory_stage memory_stage_inst (
        .clk(clk),
        .rst(rst),
        .ena(ena),
        .mem_result(mem_result),
        .mem_store_data(mem_store_data),
        .mem_dst(mem_dst),
        .mem_wena(mem_wena),
        .mem_load(mem_load),
        .mem_store(mem_store),
        .mem_fwd_data(mem_fwd_data),
        .wb_data(wb_data),
        .wb_dst(wb_dst),
        .wb_wena(wb_wena)
    );

endmodule

// ==== hdl/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ena,
    input  cpu_pipe_pkg::word_t     mem_result,
    input  cpu_pipe_pkg::word_t     mem_store_data,
    input  cpu_pipe_pkg::reg_addr_t mem_dst,
    input  logic                    mem_wena,
    input  logic                    mem_load,
    input  logic                    mem_store,
    output cpu_pipe_pkg::word_t     mem_fwd_data,
    output cpu_pipe_pkg::word_t     wb_data,
    output cpu_pipe_pkg::reg_addr_t wb_dst,
    output logic                    wb_wena
);

    cpu_pipe_pkg::word_t                 dmem [cpu_pipe_pkg::DMEM_WORDS];
    logic [cpu_pipe_pkg::DMEM_AW-1:0]    dmem_addr;
    cpu_pipe_pkg::word_t                 load_data;

    // Byte address to word index
    assign dmem_addr = mem_result[cpu_pipe_pkg::DMEM_AW+1:2];
    assign load_data = dmem[dmem_addr];

    always_ff @(posedge clk) begin
        if (ena && mem_store) begin
            dmem[dmem_addr] <= mem_store_data;
        end
    end

    // Also the forwarding source for decode
    assign mem_fwd_data = mem_load ? load_data : mem_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_wena <= 1'b0;
        end else if (ena) begin
            wb_wena <= mem_wena;
        end
    end

    always_ff @(posedge clk) begin
        if (ena) begin
            wb_data <= mem_fwd_data;
            wb_dst  <= mem_dst;
        end
    end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ena,
    input  cpu_pipe_pkg::alu_op_e   ex_op,
    input  cpu_pipe_pkg::word_t     ex_a,
    input  cpu_pipe_pkg::word_t     ex_b,
    input  cpu_pipe_pkg::word_t     ex_store_data,
    input  cpu_pipe_pkg::reg_addr_t ex_dst,
    input  logic                    ex_wena,
    input  logic                    ex_load,
    input  logic                    ex_store,
    output cpu_pipe_pkg::word_t     ex_result,
    output cpu_pipe_pkg::word_t     mem_result,
    output cpu_pipe_pkg::word_t     mem_store_data,
    output cpu_pipe_pkg::reg_addr_t mem_dst,
    output logic                    mem_wena,
    output logic                    mem_load,
    output logic                    mem_store
);

    always_comb begin
        case (ex_op)
            cpu_pipe_pkg::ALU_ADD: ex_result = ex_a + ex_b;
            cpu_pipe_pkg::ALU_SUB: ex_result = ex_a - ex_b;
            cpu_pipe_pkg::ALU_AND: ex_result = ex_a & ex_b;
            cpu_pipe_pkg::ALU_OR:  ex_result = ex_a | ex_b;
            // Signed compare
            cpu_pipe_pkg::ALU_SLT: begin
                ex_result = {{(cpu_pipe_pkg::XLEN-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
            end
            default:               ex_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wena  <= 1'b0;
            mem_load  <= 1'b0;
            mem_store <= 1'b0;
        end else if (ena) begin
            mem_wena  <= ex_wena;
            mem_load  <= ex_load;
            mem_store <= ex_store;
        end
    end

    always_ff @(posedge clk) begin
        if (ena) begin
            mem_result     <= ex_result;
            mem_store_data <= ex_store_data;
            mem_dst        <= ex_dst;
        end
    end

endmodule

// ==== decode/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ena,
    input  cpu_pipe_pkg::word_t     if_pc4,
    input  cpu_pipe_pkg::word_t     if_instr,
    input  cpu_pipe_pkg::word_t     ex_result,
    input  cpu_pipe_pkg::word_t     mem_fwd_data,
    input  cpu_pipe_pkg::reg_addr_t mem_dst,
    input  logic                    mem_wena,
    input  cpu_pipe_pkg::word_t     wb_data,
    input  cpu_pipe_pkg::reg_addr_t wb_dst,
    input  logic                    wb_wena,
    input  cpu_pipe_pkg::reg_addr_t dbg_addr,
    output logic                    stall,
    output logic                    branch_taken,
    output cpu_pipe_pkg::word_t     branch_target,
    output cpu_pipe_pkg::alu_op_e   ex_op,
    output cpu_pipe_pkg::word_t     ex_a,
    output cpu_pipe_pkg::word_t     ex_b,
    output cpu_pipe_pkg::word_t     ex_store_data,
    output cpu_pipe_pkg::reg_addr_t ex_dst,
    output logic                    ex_wena,
    output logic                    ex_load,
    output logic                    ex_store,
    output cpu_pipe_pkg::word_t     dbg_data
);

    localparam int RA_W = $bits(cpu_pipe_pkg::reg_addr_t);
    localparam int IMM_W = cpu_isa_pkg::IMM_WIDTH;

    cpu_isa_pkg::opcode_e    opcode;
    cpu_isa_pkg::funct_e     funct;
    cpu_pipe_pkg::reg_addr_t rs;
    cpu_pipe_pkg::reg_addr_t rt;
    cpu_pipe_pkg::reg_addr_t rd;
    cpu_pipe_pkg::word_t     imm_ext;
    cpu_pipe_pkg::word_t     rf_rs;
    cpu_pipe_pkg::word_t     rf_rt;
    cpu_pipe_pkg::word_t     rs_val;
    cpu_pipe_pkg::word_t     rt_val;

    cpu_pipe_pkg::alu_op_e   id_op;
    cpu_pipe_pkg::reg_addr_t id_dst;
    logic                    id_wena;
    logic                    id_load;
    logic                    id_store;
    logic                    id_use_imm;
    logic                    uses_rs;
    logic                    uses_rt;
    logic                    is_beq;
    logic                    is_bne;
    logic                    operands_equal;

    assign opcode  = cpu_isa_pkg::opcode_e'(if_instr[cpu_isa_pkg::OPCODE_MSB -: 6]);
    assign funct   = cpu_isa_pkg::funct_e'(if_instr[cpu_isa_pkg::FUNCT_MSB -: 6]);
    assign rs      = if_instr[cpu_isa_pkg::RS_MSB -: RA_W];
    assign rt      = if_instr[cpu_isa_pkg::RT_MSB -: RA_W];
    assign rd      = if_instr[cpu_isa_pkg::RD_MSB -: RA_W];
    assign imm_ext = {{(cpu_pipe_pkg::XLEN - IMM_W){if_instr[IMM_W-1]}}, if_instr[IMM_W-1:0]};

    always_comb begin
        id_op      = cpu_pipe_pkg::ALU_ADD;
        id_dst     = rt;
        id_wena    = 1'b0;
        id_load    = 1'b0;
        id_store   = 1'b0;
        id_use_imm = 1'b0;
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;
        is_beq     = 1'b0;
        is_bne     = 1'b0;
        case (opcode)
            cpu_isa_pkg::OP_SPECIAL: begin
                id_dst  = rd;
                id_wena = 1'b1;
                case (funct)
                    cpu_isa_pkg::FN_ADDU: id_op = cpu_pipe_pkg::ALU_ADD;
                    cpu_isa_pkg::FN_SUBU: id_op = cpu_pipe_pkg::ALU_SUB;
                    cpu_isa_pkg::FN_AND:  id_op = cpu_pipe_pkg::ALU_AND;
                    cpu_isa_pkg::FN_OR:   id_op = cpu_pipe_pkg::ALU_OR;
                    cpu_isa_pkg::FN_SLT:  id_op = cpu_pipe_pkg::ALU_SLT;
                    default:              id_wena = 1'b0;
                endcase
                uses_rs = id_wena;
                uses_rt = id_wena;
            end
            cpu_isa_pkg::OP_ADDIU: begin
                id_wena    = 1'b1;
                id_use_imm = 1'b1;
                uses_rs    = 1'b1;
            end
            cpu_isa_pkg::OP_LW: begin
                id_wena    = 1'b1;
                id_load    = 1'b1;
                id_use_imm = 1'b1;
                uses_rs    = 1'b1;
            end
            cpu_isa_pkg::OP_SW: begin
                id_store   = 1'b1;
                id_use_imm = 1'b1;
                uses_rs    = 1'b1;
                uses_rt    = 1'b1;
            end
            cpu_isa_pkg::OP_BEQ: begin
                is_beq  = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            cpu_isa_pkg::OP_BNE: begin
                is_bne  = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            default: ;
        endcase
    end

    // Youngest producer wins, the register file covers write-back
    function automatic cpu_pipe_pkg::word_t forward(input cpu_pipe_pkg::reg_addr_t addr,
                                                    input cpu_pipe_pkg::word_t rf_val);
        if (addr == '0) begin
            return '0;
        end
        if (ex_wena && ex_dst == addr) begin
            return ex_result;
        end
        if (mem_wena && mem_dst == addr) begin
            return mem_fwd_data;
        end
        return rf_val;
    endfunction

    assign rs_val = forward(rs, rf_rs);
    assign rt_val = forward(rt, rf_rt);

    // A load still in execute has only its address, so wait one cycle
    assign stall = ex_load && ex_dst != '0 &&
                   ((uses_rs && ex_dst == rs) || (uses_rt && ex_dst == rt));

    assign operands_equal = rs_val == rt_val;
    assign branch_taken   = ((is_beq && operands_equal) || (is_bne && !operands_equal)) && !stall;
    assign branch_target  = if_pc4 + {imm_ext[cpu_pipe_pkg::XLEN-3:0], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_op    <= cpu_pipe_pkg::ALU_ADD;
            ex_wena  <= 1'b0;
            ex_load  <= 1'b0;
            ex_store <= 1'b0;
        end else if (ena) begin
            ex_op    <= id_op;
            ex_wena  <= id_wena && id_dst != '0 && !stall;
            ex_load  <= id_load && !stall;
            ex_store <= id_store && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (ena) begin
            ex_a          <= rs_val;
            ex_b          <= id_use_imm ? imm_ext : rt_val;
            ex_store_data <= rt_val;
            ex_dst        <= id_dst;
        end
    end

    // Frozen pipeline must not commit the held write-back
    reg_file reg_file_inst (
        .clk(clk),
        .rst(rst),
        .wena(wb_wena && ena),
        .waddr(wb_dst),
        .raddr_a(rs),
        .raddr_b(rt),
        .dbg_addr(dbg_addr),
        .wdata(wb_data),
        .rdata_a(rf_rs),
        .rdata_b(rf_rt),
        .dbg_data(dbg_data)
    );

endmodule

// ==== decode/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wena,
    input  cpu_pipe_pkg::reg_addr_t waddr,
    input  cpu_pipe_pkg::reg_addr_t raddr_a,
    input  cpu_pipe_pkg::reg_addr_t raddr_b,
    input  cpu_pipe_pkg::reg_addr_t dbg_addr,
    input  cpu_pipe_pkg::word_t     wdata,
    output cpu_pipe_pkg::word_t     rdata_a,
    output cpu_pipe_pkg::word_t     rdata_b,
    output cpu_pipe_pkg::word_t     dbg_data
);

    cpu_pipe_pkg::word_t regs [cpu_pipe_pkg::REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpu_pipe_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wena && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write is visible on every read port
    function automatic cpu_pipe_pkg::word_t read_port(input cpu_pipe_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        return (wena && waddr == addr) ? wdata : regs[addr];
    endfunction

    always_comb begin
        rdata_a  = read_port(raddr_a);
        rdata_b  = read_port(raddr_b);
        dbg_data = read_port(dbg_addr);
    end

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                ena,
    input  logic                stall,
    input  logic                branch_taken,
    input  cpu_pipe_pkg::word_t branch_target,
    input  cpu_pipe_pkg::word_t instr,
    output cpu_pipe_pkg::word_t pc,
    output cpu_pipe_pkg::word_t if_pc4,
    output cpu_pipe_pkg::word_t if_instr
);

    cpu_pipe_pkg::word_t pc4;
    cpu_pipe_pkg::word_t next_pc;

    assign pc4     = pc + cpu_pipe_pkg::XLEN'(cpu_pipe_pkg::PC_STEP);
    assign next_pc = branch_taken ? branch_target : pc4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (ena && !stall) begin
            pc <= next_pc;
        end
    end

    // The slot behind a taken branch enters IF/ID as a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            if_instr <= '0;
        end else if (ena && !stall) begin
            if_instr <= branch_taken ? '0 : instr;
        end
    end

    always_ff @(posedge clk) begin
        if (ena && !stall) begin
            if_pc4 <= pc4;
        end
    end

endmodule

// ==== common/cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] word_t;

    localparam int REG_COUNT = 32;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

    // Operations carried from decode into the ALU
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // Data memory, word addressed
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

    localparam int PC_STEP = 4;

endpackage

// ==== common/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    // Primary opcodes of the supported MIPS subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL (R-type) instructions
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    // Field positions inside the instruction word
    localparam int OPCODE_MSB = 31;
    localparam int RS_MSB     = 25;
    localparam int RT_MSB     = 20;
    localparam int RD_MSB     = 15;
    localparam int FUNCT_MSB  = 5;
    localparam int IMM_WIDTH  = 16;

endpackage
